// File: verilog/video_pkg.sv
`default_nettype none

package video_pkg;

// horizontal raster, visible pixels come first then the porches
localparam int VISIBLE_WIDTH    = 32;
localparam int H_FRONT_PORCH    = 2;
localparam int H_SYNC_WIDTH     = 4;
localparam int H_BACK_PORCH     = 2;
localparam int TOTAL_WIDTH      = VISIBLE_WIDTH + H_FRONT_PORCH + H_SYNC_WIDTH + H_BACK_PORCH;
localparam int H_SYNC_START     = VISIBLE_WIDTH + H_FRONT_PORCH;
localparam int H_SYNC_END       = H_SYNC_START + H_SYNC_WIDTH;

// vertical raster, same order in lines
localparam int VISIBLE_HEIGHT   = 12;
localparam int V_FRONT_PORCH    = 1;
localparam int V_SYNC_WIDTH     = 2;
localparam int V_BACK_PORCH     = 1;
localparam int TOTAL_HEIGHT     = VISIBLE_HEIGHT + V_FRONT_PORCH + V_SYNC_WIDTH + V_BACK_PORCH;
localparam int V_SYNC_START     = VISIBLE_HEIGHT + V_FRONT_PORCH;
localparam int V_SYNC_END       = V_SYNC_START + V_SYNC_WIDTH;

localparam int HRES_W           = $clog2(TOTAL_WIDTH);      // 6 bits, 40..63 never match
localparam int VRES_W           = $clog2(TOTAL_HEIGHT);

// 4-bpp pointer image, four pixels per word
localparam int POINTER_SIZE     = 8;
localparam int POINTER_ADDR_W   = $clog2(POINTER_SIZE * POINTER_SIZE / 4);
localparam int PTR_CNT_W        = $clog2(POINTER_SIZE) + 1;   // extra bit for the stop state
localparam int PTR_H_END        = POINTER_SIZE + 3;           // 3 extra for the word load latency

typedef logic [HRES_W-1:0]          hres_t;
typedef logic [VRES_W-1:0]          vres_t;
typedef logic [15:0]                word_t;
typedef logic [7:0]                 color_t;
typedef logic [POINTER_ADDR_W-1:0]  pointer_addr_t;

// register numbers
localparam logic [3:0] REG_VID_CTRL     = 4'h0;     // border colour [7:0]
localparam logic [3:0] REG_SCANLINE     = 4'h1;     // read only
localparam logic [3:0] REG_VID_LEFT     = 4'h2;
localparam logic [3:0] REG_VID_RIGHT    = 4'h3;
localparam logic [3:0] REG_POINTER_H    = 4'h4;
localparam logic [3:0] REG_POINTER_V    = 4'h5;     // colour group [15:12]
localparam logic [3:0] REG_FILL_CTRL    = 4'h6;     // fill colour [15:8], blank [7]

// configuration after reset
localparam color_t RESET_BORDER         = 8'h08;    // grey
localparam hres_t  RESET_RIGHT          = hres_t'(VISIBLE_WIDTH);
localparam logic   RESET_FILL_BLANK     = 1'b1;

typedef struct packed {
    hres_t  h_count;
    vres_t  v_count;
    logic   h_visible;
    logic   v_visible;
    logic   hsync;
    logic   vsync;
    logic   end_of_line;                            // last count of a line
    logic   end_of_frame;                           // last count of a frame
    logic   end_of_visible;                         // last count of the last visible line
} beam_t;

typedef struct packed {
    color_t border_color;
    color_t fill_color;
    logic   fill_blank;
    hres_t  vid_left;                               // first fill pixel
    hres_t  vid_right;                              // first border pixel after the fill
} vid_cfg_t;

typedef struct packed {
    hres_t      pointer_h;
    vres_t      pointer_v;
    logic [3:0] pointer_col;                        // upper nibble of the pointer colour
} pointer_cfg_t;

endpackage

`default_nettype wire

// File: verilog/video_timing.sv
`default_nettype none
`timescale 1ns/1ns

module video_timing import video_pkg::*; (
    input  wire logic   clk,
    input  wire logic   reset_i,
    output      beam_t  beam_o
);

hres_t  h_count;
vres_t  v_count;
logic   end_of_line;
logic   end_of_frame;
logic   end_of_visible;

assign end_of_line      = (h_count == hres_t'(TOTAL_WIDTH - 1));
assign end_of_frame     = end_of_line && (v_count == vres_t'(TOTAL_HEIGHT - 1));
assign end_of_visible   = end_of_line && (v_count == vres_t'(VISIBLE_HEIGHT - 1));

// beam position counters
always_ff @(posedge clk) begin
    if (reset_i) begin
        h_count <= '0;
        v_count <= '0;
    end else begin
        h_count <= h_count + 1'b1;
        if (end_of_line) begin
            h_count <= '0;
            v_count <= v_count + 1'b1;              // next line
        end
        if (end_of_frame) begin
            v_count <= '0;                          // back to the top
        end
    end
end

// flags derived from the counters
always_comb begin
    beam_o.h_count          = h_count;
    beam_o.v_count          = v_count;
    beam_o.h_visible        = (h_count < hres_t'(VISIBLE_WIDTH));
    beam_o.v_visible        = (v_count < vres_t'(VISIBLE_HEIGHT));
    beam_o.hsync            = (h_count >= hres_t'(H_SYNC_START)) &&
                              (h_count < hres_t'(H_SYNC_END));
    beam_o.vsync            = (v_count >= vres_t'(V_SYNC_START)) &&
                              (v_count < vres_t'(V_SYNC_END));
    beam_o.end_of_line      = end_of_line;
    beam_o.end_of_frame     = end_of_frame;
    beam_o.end_of_visible   = end_of_visible;
end

endmodule

`default_nettype wire

// File: verilog/video_regs.sv
`default_nettype none
`timescale 1ns/1ns

module video_regs import video_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire logic           reg_wr_en_i,        // write strobe, one cycle
    input  wire logic [3:0]     reg_num_i,
    input  wire word_t          reg_data_i,
    input  wire beam_t          beam_i,
    output      word_t          reg_data_o,         // valid the cycle after reg_num_i
    output      logic           video_intr_o,       // vblank pulse
    output      vid_cfg_t       vid_cfg_o,
    output      pointer_cfg_t   pointer_cfg_o
);

word_t  rd_data;

// register writes and vblank interrupt
always_ff @(posedge clk) begin
    if (reset_i) begin
        video_intr_o                <= 1'b0;
        vid_cfg_o.border_color      <= RESET_BORDER;
        vid_cfg_o.fill_color        <= '0;
        vid_cfg_o.fill_blank        <= RESET_FILL_BLANK;
        vid_cfg_o.vid_left          <= '0;
        vid_cfg_o.vid_right         <= RESET_RIGHT;
        pointer_cfg_o.pointer_h     <= '0;
        pointer_cfg_o.pointer_v     <= '0;
        pointer_cfg_o.pointer_col   <= '0;
    end else begin
        video_intr_o <= beam_i.end_of_visible;

        if (reg_wr_en_i) begin
            case (reg_num_i)
                REG_VID_CTRL: begin
                    vid_cfg_o.border_color <= reg_data_i[7:0];
                end
                REG_VID_LEFT: begin
                    vid_cfg_o.vid_left <= reg_data_i[HRES_W-1:0];
                end
                REG_VID_RIGHT: begin
                    vid_cfg_o.vid_right <= reg_data_i[HRES_W-1:0];
                end
                REG_POINTER_H: begin
                    pointer_cfg_o.pointer_h <= reg_data_i[HRES_W-1:0];
                end
                REG_POINTER_V: begin
                    pointer_cfg_o.pointer_v     <= reg_data_i[VRES_W-1:0];
                    pointer_cfg_o.pointer_col   <= reg_data_i[15:12];
                end
                REG_FILL_CTRL: begin
                    vid_cfg_o.fill_color    <= reg_data_i[15:8];
                    vid_cfg_o.fill_blank    <= reg_data_i[7];
                end
                default: begin
                    // scanline is read only, rest unused
                end
            endcase
        end
    end
end

// readback mux, same layout as the writes
always_comb begin
    rd_data = '0;
    case (reg_num_i)
        REG_VID_CTRL: begin
            rd_data = {8'h00, vid_cfg_o.border_color};
        end
        REG_SCANLINE: begin
            rd_data = word_t'(beam_i.v_count);
        end
        REG_VID_LEFT: begin
            rd_data = word_t'(vid_cfg_o.vid_left);
        end
        REG_VID_RIGHT: begin
            rd_data = word_t'(vid_cfg_o.vid_right);
        end
        REG_POINTER_H: begin
            rd_data = word_t'(pointer_cfg_o.pointer_h);
        end
        REG_POINTER_V: begin
            rd_data = {pointer_cfg_o.pointer_col, {(12 - VRES_W){1'b0}},
                       pointer_cfg_o.pointer_v};
        end
        REG_FILL_CTRL: begin
            rd_data = {vid_cfg_o.fill_color, vid_cfg_o.fill_blank, 7'b0};
        end
        default: begin
        end
    endcase
end

always_ff @(posedge clk) begin
    reg_data_o <= rd_data;                          // one cycle read latency
end

endmodule

`default_nettype wire

// File: verilog/pointer_sprite.sv
`default_nettype none
`timescale 1ns/1ns

// The first pointer pixel leaves this block while h_count is pointer_h + 5,
// so the sprite sits five pixels right of its programmed position.
module pointer_sprite import video_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire beam_t          beam_i,
    input  wire pointer_cfg_t   pointer_cfg_i,
    input  wire word_t          pointer_data_i,     // image word, same cycle as the address
    output      pointer_addr_t  pointer_addr_o,
    output      logic [3:0]     pointer_color_o     // 0 is transparent
);

logic [PTR_CNT_W-1:0]   h_cnt;                      // pixel within the row, plus load lead-in
logic [PTR_CNT_W-1:0]   v_cnt;                      // row, msb set once past the bottom
word_t                  pointer_word;               // nibbles shift out from the top
logic                   h_draw;
logic                   v_draw;

assign h_draw           = (h_cnt < PTR_CNT_W'(PTR_H_END));
assign v_draw           = !v_cnt[PTR_CNT_W-1];
assign pointer_addr_o   = {v_cnt[PTR_CNT_W-2:0], h_cnt[PTR_CNT_W-2:2]};  // row, word in row
assign pointer_color_o  = pointer_word[15:12];

always_ff @(posedge clk) begin
    if (reset_i) begin
        h_cnt           <= PTR_CNT_W'(PTR_H_END);   // parked, nothing drawn
        v_cnt           <= PTR_CNT_W'(POINTER_SIZE);
        pointer_word    <= '0;
    end else begin
        pointer_word <= {pointer_word[11:0], 4'h0}; // next pixel

        if (h_draw) begin
            h_cnt <= h_cnt + 1'b1;
        end

        // row starts on the horizontal match, one row per line
        if (beam_i.h_count == pointer_cfg_i.pointer_h) begin
            h_cnt <= '0;
            if (v_draw) begin
                v_cnt <= v_cnt + 1'b1;
            end
            if (beam_i.v_count == pointer_cfg_i.pointer_v) begin
                v_cnt <= '0;                        // top row
            end
        end

        if (h_cnt[1:0] == 2'b11) begin
            pointer_word <= pointer_data_i;         // every fourth pixel
        end

        if (!h_draw || !v_draw) begin
            pointer_word <= '0;                     // outside the sprite
        end
    end
end

endmodule

`default_nettype wire

// File: verilog/pixel_out.sv
`default_nettype none
`timescale 1ns/1ns

module pixel_out import video_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset_i,
    input  wire beam_t          beam_i,
    input  wire vid_cfg_t       vid_cfg_i,
    input  wire pointer_cfg_t   pointer_cfg_i,
    input  wire logic [3:0]     pointer_color_i,
    output      color_t         color_index_o,
    output      logic           hsync_o,
    output      logic           vsync_o,
    output      logic           dv_de_o,
    output      logic           h_blank_o,
    output      logic           v_blank_o
);

logic   visible;
logic   in_window;
color_t color_next;

assign visible      = beam_i.h_visible && beam_i.v_visible;
assign in_window    = (beam_i.h_count >= vid_cfg_i.vid_left) &&
                      (beam_i.h_count < vid_cfg_i.vid_right);

always_comb begin
    color_next = vid_cfg_i.border_color;
    if (in_window && !vid_cfg_i.fill_blank) begin
        color_next = vid_cfg_i.fill_color;
    end
    if (pointer_color_i != 4'h0) begin
        color_next = {pointer_cfg_i.pointer_col, pointer_color_i};  // pointer on top
    end
    if (!visible) begin
        color_next = '0;
    end
end

// everything registered together so sync and colour stay aligned
always_ff @(posedge clk) begin
    if (reset_i) begin
        color_index_o   <= '0;
        hsync_o         <= 1'b0;
        vsync_o         <= 1'b0;
        dv_de_o         <= 1'b0;
        h_blank_o       <= 1'b0;
        v_blank_o       <= 1'b0;
    end else begin
        color_index_o   <= color_next;
        hsync_o         <= beam_i.hsync;
        vsync_o         <= beam_i.vsync;
        dv_de_o         <= visible;
        h_blank_o       <= !beam_i.h_visible;
        v_blank_o       <= !beam_i.v_visible;
    end
end

endmodule

`default_nettype wire

// File: verilog/video_gen.sv
`default_nettype none
`timescale 1ns/1ns

module video_gen import video_pkg::*; (
    input  wire logic           clk,
    input  wire logic           reset_i,
    // register port
    input  wire logic           reg_wr_en_i,
    input  wire logic [3:0]     reg_num_i,
    input  wire word_t          reg_data_i,
    output      word_t          reg_data_o,
    output      logic           video_intr_o,
    // pointer image memory, asynchronous read
    output      pointer_addr_t  pointer_addr_o,
    input  wire word_t          pointer_data_i,
    // video out
    output      color_t         color_index_o,
    output      logic           hsync_o,
    output      logic           vsync_o,
    output      logic           dv_de_o,
    output      logic           h_blank_o,
    output      logic           v_blank_o
);

beam_t          beam;
vid_cfg_t       vid_cfg;
pointer_cfg_t   pointer_cfg;
logic [3:0]     pointer_color;

video_timing u_timing (
    .clk            (clk),
    .reset_i        (reset_i),
    .beam_o         (beam)
);

video_regs u_regs (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .reg_num_i      (reg_num_i),
    .reg_data_i     (reg_data_i),
    .beam_i         (beam),
    .reg_data_o     (reg_data_o),
    .video_intr_o   (video_intr_o),
    .vid_cfg_o      (vid_cfg),
    .pointer_cfg_o  (pointer_cfg)
);

pointer_sprite u_pointer (
    .clk                (clk),
    .reset_i            (reset_i),
    .beam_i             (beam),
    .pointer_cfg_i      (pointer_cfg),
    .pointer_data_i     (pointer_data_i),
    .pointer_addr_o     (pointer_addr_o),
    .pointer_color_o    (pointer_color)
);

pixel_out u_pixel (
    .clk                (clk),
    .reset_i            (reset_i),
    .beam_i             (beam),
    .vid_cfg_i          (vid_cfg),
    .pointer_cfg_i      (pointer_cfg),
    .pointer_color_i    (pointer_color),
    .color_index_o      (color_index_o),
    .hsync_o            (hsync_o),
    .vsync_o            (vsync_o),
    .dv_de_o            (dv_de_o),
    .h_blank_o          (h_blank_o),
    .v_blank_o          (v_blank_o)
);

endmodule

`default_nettype wire

// File: sim/tb_video_gen.sv
`default_nettype none
`timescale 1ns/1ns

module tb_video_gen import video_pkg::*; ();

localparam int FRAME_CYCLES     = TOTAL_WIDTH * TOTAL_HEIGHT;
localparam int NUM_CASES        = 10;
localparam int TIMEOUT_CYCLES   = 2 * (NUM_CASES + 6 * FRAME_CYCLES);
localparam int POINTER_WORDS    = 2 ** POINTER_ADDR_W;

typedef struct packed {
    logic [3:0] num;
    word_t      wdata;
    word_t      rdata;                              // expected readback
} reg_case_t;

logic           clk;
logic           reset_i;
logic           reg_wr_en_i;
logic [3:0]     reg_num_i;
word_t          reg_data_i;
word_t          reg_data_o;
logic           video_intr_o;
pointer_addr_t  pointer_addr_o;
word_t          pointer_data_i;
color_t         color_index_o;
logic           hsync_o;
logic           vsync_o;
logic           dv_de_o;
logic           h_blank_o;
logic           v_blank_o;

reg_case_t      reg_table [0:NUM_CASES-1];
word_t          pointer_mem [0:POINTER_WORDS-1];
int             errors;
int             tests_passed;
int             tests_failed;
int             cycle_count;

// results of the last sampled frame
int de_cycles, hsync_rises, bad_hsync, vsync_cycles, intr_pulses;
int fill_cycles, border_cycles, pointer_cycles, other_cycles;
int lines_seen, min_line_fill, max_line_fill;
int hblank_cycles, vblank_cycles, blank_bad, pointer_bad;

video_gen DUT (
    .clk            (clk),
    .reset_i        (reset_i),
    .reg_wr_en_i    (reg_wr_en_i),
    .reg_num_i      (reg_num_i),
    .reg_data_i     (reg_data_i),
    .reg_data_o     (reg_data_o),
    .video_intr_o   (video_intr_o),
    .pointer_addr_o (pointer_addr_o),
    .pointer_data_i (pointer_data_i),
    .color_index_o  (color_index_o),
    .hsync_o        (hsync_o),
    .vsync_o        (vsync_o),
    .dv_de_o        (dv_de_o),
    .h_blank_o      (h_blank_o),
    .v_blank_o      (v_blank_o)
);

assign pointer_data_i = pointer_mem[pointer_addr_o];    // asynchronous image memory

initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
end

initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
        @(posedge clk);
        cycle_count++;
    end
    $display("ERROR: simulation did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
end

function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) begin
        return (state >> 1) ^ 32'h80200003;
    end
    return state >> 1;
endfunction

task automatic fill_pointer_image();
    logic [31:0] lfsr;
    logic [3:0]  nibble;
    lfsr = 32'h360d;
    for (int a = 0; a < POINTER_WORDS; a++) begin
        for (int n = 0; n < 4; n++) begin
            nibble = 4'h0;
            for (int b = 0; b < 4; b++) begin
                lfsr = lfsr_next(lfsr);             // one step per bit
                nibble = {nibble[2:0], lfsr[0]};
            end
            if (nibble == 4'h0) begin
                nibble = 4'h1;                      // zero is transparent
            end
            pointer_mem[a][n*4 +: 4] = nibble;
        end
    end
endtask

// image nibble of the k-th pointer pixel in raster order
function automatic logic [3:0] expected_pointer_nibble(input int k);
    int    row;
    int    col;
    word_t word;
    if (k >= POINTER_SIZE * POINTER_SIZE) begin
        return 4'h0;
    end
    row  = k / POINTER_SIZE;
    col  = k % POINTER_SIZE;
    word = pointer_mem[row * (POINTER_SIZE / 4) + col / 4];
    return word[(3 - col % 4) * 4 +: 4];            // leftmost pixel in the top nibble
endfunction

task automatic load_reg_table();
    reg_table[0] = {REG_VID_CTRL,  16'hA5C3, 16'h00C3};
    reg_table[1] = {REG_VID_LEFT,  16'hFF0A, 16'h000A};
    reg_table[2] = {REG_VID_RIGHT, 16'h0118, 16'h0018};
    reg_table[3] = {REG_POINTER_H, 16'hFFFF, 16'h003F};
    reg_table[4] = {REG_POINTER_V, 16'h7AB5, 16'h7005};    // group 7, line 5
    reg_table[5] = {REG_FILL_CTRL, 16'h3CFF, 16'h3C80};
    reg_table[6] = {REG_FILL_CTRL, 16'h5A7F, 16'h5A00};
    reg_table[7] = {4'h7,          16'h1234, 16'h0000};    // unused
    reg_table[8] = {4'hF,          16'hFFFF, 16'h0000};
    reg_table[9] = {REG_VID_CTRL,  16'h0011, 16'h0011};
endtask

task automatic check_value(input string what, input int got, input int expected);
    assert (got == expected) else begin
        $display("mismatch %s: got 0x%0h, expected 0x%0h", what, got, expected);
        errors++;
    end
endtask

// called at a falling edge, returns at a falling edge
task automatic write_reg(input logic [3:0] num, input word_t data);
    reg_wr_en_i = 1'b1;
    reg_num_i   = num;
    reg_data_i  = data;
    @(negedge clk);
    reg_wr_en_i = 1'b0;
endtask

task automatic read_reg(input logic [3:0] num, output word_t data);
    reg_wr_en_i = 1'b0;
    reg_num_i   = num;
    @(negedge clk);
    data = reg_data_o;
endtask

// waits for the vblank interrupt, then collects one whole frame of output
task automatic sample_frame(input color_t fill, input color_t border, input logic [3:0] pcol);
    int   waited;
    int   hs_run;
    int   line_fill;
    logic prev_de;
    logic prev_hs;
    waited = 0;
    {de_cycles, hsync_rises, bad_hsync, vsync_cycles, intr_pulses} = '0;
    {fill_cycles, border_cycles, pointer_cycles, other_cycles, lines_seen} = '0;
    {hblank_cycles, vblank_cycles, blank_bad, pointer_bad} = '0;
    min_line_fill = FRAME_CYCLES;
    max_line_fill = -1;
    while (!video_intr_o && waited < 2 * FRAME_CYCLES) begin
        @(negedge clk);
        waited++;
    end
    assert (video_intr_o) else begin
        $display("ERROR: no vblank interrupt seen within two frames");
        errors++;
    end
    prev_de   = dv_de_o;
    prev_hs   = hsync_o;
    hs_run    = 0;
    line_fill = 0;
    repeat (FRAME_CYCLES) begin
        @(negedge clk);
        if (video_intr_o) intr_pulses++;
        if (vsync_o) vsync_cycles++;
        if (h_blank_o) hblank_cycles++;
        if (v_blank_o) vblank_cycles++;
        if (dv_de_o == (h_blank_o || v_blank_o)) begin
            blank_bad++;                            // de must be low in either blank
        end
        if (hsync_o) begin
            if (!prev_hs) begin
                hsync_rises++;
                hs_run = 0;
            end
            hs_run++;
        end else if (prev_hs && hs_run != H_SYNC_WIDTH) begin
            bad_hsync++;
        end
        if (dv_de_o) begin
            de_cycles++;
            if (color_index_o[7:4] == pcol) begin
                if (color_index_o[3:0] != expected_pointer_nibble(pointer_cycles)) begin
                    pointer_bad++;
                end
                pointer_cycles++;
            end else if (color_index_o == fill) begin
                fill_cycles++;
                line_fill++;
            end else if (color_index_o == border) begin
                border_cycles++;
            end else begin
                other_cycles++;
            end
        end else if (prev_de) begin             // end of a visible line
            lines_seen++;
            if (line_fill < min_line_fill) min_line_fill = line_fill;
            if (line_fill > max_line_fill) max_line_fill = line_fill;
            line_fill = 0;
        end
        prev_de = dv_de_o;
        prev_hs = hsync_o;
    end
endtask

task automatic report_test(input string name, input int errors_at_start);
    if (errors == errors_at_start) begin
        $display("test %s: passed", name);
        tests_passed++;
    end else begin
        $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        tests_failed++;
    end
endtask

initial begin
    word_t data;
    int    mark;
    int    prev_line;
    reset_i      = 1'b1;
    reg_wr_en_i  = 1'b0;
    reg_num_i    = 4'h0;
    reg_data_i   = '0;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    fill_pointer_image();
    load_reg_table();
    repeat (5) @(posedge clk);
    @(negedge clk);

    mark = errors;
    check_value("dv_de_o", dv_de_o, 0);
    check_value("video_intr_o", video_intr_o, 0);
    check_value("hsync_o", hsync_o, 0);
    check_value("vsync_o", vsync_o, 0);
    check_value("color_index_o", color_index_o, 0);
    reset_i = 1'b0;
    read_reg(REG_VID_CTRL, data);
    check_value("reg_data_o REG_VID_CTRL", data, {8'h00, RESET_BORDER});
    read_reg(REG_VID_RIGHT, data);
    check_value("reg_data_o REG_VID_RIGHT", data, int'(RESET_RIGHT));
    read_reg(REG_FILL_CTRL, data);
    check_value("reg_data_o REG_FILL_CTRL", data, {8'h00, RESET_FILL_BLANK, 7'h00});
    check_value("video_intr_o", video_intr_o, 0);   // still on the first line
    report_test("reset values", mark);

    mark = errors;
    for (int i = 0; i < NUM_CASES; i++) begin
        write_reg(reg_table[i].num, reg_table[i].wdata);
        read_reg(reg_table[i].num, data);
        check_value($sformatf("reg_data_o reg %0d", reg_table[i].num), data,
                    reg_table[i].rdata);
    end
    report_test("register read and write", mark);

    mark = errors;
    sample_frame(8'h5A, 8'h11, 4'h7);
    check_value("dv_de_o high cycles", de_cycles, VISIBLE_WIDTH * VISIBLE_HEIGHT);
    check_value("hsync_o rising edges", hsync_rises, TOTAL_HEIGHT);
    check_value("hsync_o pulses of wrong width", bad_hsync, 0);
    check_value("vsync_o high cycles", vsync_cycles, V_SYNC_WIDTH * TOTAL_WIDTH);
    check_value("h_blank_o high cycles", hblank_cycles,
                (TOTAL_WIDTH - VISIBLE_WIDTH) * TOTAL_HEIGHT);
    check_value("v_blank_o high cycles", vblank_cycles,
                (TOTAL_HEIGHT - VISIBLE_HEIGHT) * TOTAL_WIDTH);
    check_value("dv_de_o cycles not matching the blanks", blank_bad, 0);
    report_test("frame timing", mark);

    mark = errors;
    check_value("video_intr_o pulses per frame", intr_pulses, 1);
    for (int i = 0; i < TOTAL_HEIGHT; i++) begin
        read_reg(REG_SCANLINE, data);
        assert (data < TOTAL_HEIGHT) else begin
            $display("ERROR: scanline read %0d is not below the frame height", data);
            errors++;
        end
        if (i > 0) begin
            check_value("reg_data_o REG_SCANLINE", data, (prev_line + 1) % TOTAL_HEIGHT);
        end
        prev_line = data;
        repeat (TOTAL_WIDTH - 1) @(negedge clk);    // next read one line later
    end
    report_test("interrupt and scanline", mark);

    mark = errors;
    write_reg(REG_VID_CTRL, 16'h0011);
    write_reg(REG_VID_LEFT, 16'd6);
    write_reg(REG_VID_RIGHT, 16'd24);
    write_reg(REG_FILL_CTRL, 16'h5A00);
    write_reg(REG_POINTER_H, 16'h003F);             // never matches a beam position
    sample_frame(8'h5A, 8'h11, 4'h7);
    check_value("visible lines", lines_seen, VISIBLE_HEIGHT);
    check_value("fewest fill cycles on a line", min_line_fill, 24 - 6);
    check_value("most fill cycles on a line", max_line_fill, 24 - 6);
    check_value("border cycles", border_cycles, (VISIBLE_WIDTH - 18) * VISIBLE_HEIGHT);
    check_value("pointer cycles", pointer_cycles, 0);
    check_value("other colour cycles", other_cycles, 0);
    write_reg(REG_FILL_CTRL, 16'h5A80);             // blanked
    sample_frame(8'h5A, 8'h11, 4'h7);
    check_value("fill cycles", fill_cycles, 0);
    check_value("border cycles", border_cycles, VISIBLE_WIDTH * VISIBLE_HEIGHT);
    check_value("other colour cycles", other_cycles, 0);
    report_test("window colours", mark);

    mark = errors;
    write_reg(REG_FILL_CTRL, 16'h5A00);
    write_reg(REG_POINTER_V, 16'h7002);             // group 7, top row on line 2
    write_reg(REG_POINTER_H, 16'd4);
    sample_frame(8'h5A, 8'h11, 4'h7);
    check_value("pointer cycles", pointer_cycles, POINTER_SIZE * POINTER_SIZE);
    check_value("color_index_o pointer pixels off the image", pointer_bad, 0);
    check_value("other colour cycles", other_cycles, 0);
    check_value("dv_de_o high cycles", de_cycles, VISIBLE_WIDTH * VISIBLE_HEIGHT);
    report_test("pointer", mark);

    $display("%0d tests passed, %0d tests failed, %0d errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
        $display("RESULT: PASS");
    end else begin
        $display("RESULT: FAIL");
    end
    $finish;
end

endmodule

`default_nettype wire

// File: filelist.f
verilog/video_pkg.sv
verilog/video_timing.sv
verilog/video_regs.sv
verilog/pointer_sprite.sv
verilog/pixel_out.sv
verilog/video_gen.sv
sim/tb_video_gen.sv
